// File: Bender.yml
package:
  name: noc_bridge

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/noc_bridge_pkg.sv
      - noc_bridge/noc_bridge_deser.sv
      - src/bridge_mem.sv
      - noc_bridge/noc_bridge_ser.sv
      - noc_bridge/noc_bridge_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/noc_bridge_tb.sv

// File: all.f
+incdir+common
common/noc_bridge_pkg.sv
noc_bridge/noc_bridge_deser.sv
src/bridge_mem.sv
noc_bridge/noc_bridge_ser.sv
noc_bridge/noc_bridge_top.sv
verif/noc_bridge_tb.sv

// File: common/noc_bridge_macros.svh
// Widths are fixed for a 64-bit NoC and 64-byte lines, and MEM_LINES must be a power of two
`ifndef NOC_BRIDGE_MACROS_SVH
`define NOC_BRIDGE_MACROS_SVH

// Width of one NoC flit in bits
`define NOC_DATA_WIDTH 64

// Width of one memory line in bits, which is eight flits
`define MEM_LINE_WIDTH 512

// Number of lines in the memory stand-in
// The line index is taken from address bits 9 to 6
`define MEM_LINES 16

// Width of the header field that counts the data flits after the header
`define MSG_LENGTH_WIDTH 8

// Width of the byte address carried in the header
`define MSG_ADDR_WIDTH 16

`endif

// File: common/noc_bridge_pkg.sv
// Header layout is local to this bridge and only the four request types and their acks exist
`include "noc_bridge_macros.svh"

package noc_bridge_pkg;

  // Message type codes follow the usual tiled processor numbering
  typedef enum logic [7:0] {
    nc_load_req      = 8'd14,
    nc_store_req     = 8'd15,
    load_mem         = 8'd19,
    store_mem        = 8'd20,
    load_mem_ack     = 8'd24,
    store_mem_ack    = 8'd25,
    nc_load_mem_ack  = 8'd26,
    nc_store_mem_ack = 8'd27
  } msg_type_e;

  // Request view of a header flit
  // The dst fields address the bridge and the src fields name the requester
  typedef struct packed {
    logic [3:0]                   dst_chip;
    logic [3:0]                   dst_x;
    logic [3:0]                   dst_y;
    logic [`MSG_LENGTH_WIDTH-1:0] msg_length;
    msg_type_e                    msg_type;
    logic [4:0]                   mshrid;
    logic [2:0]                   size_log;
    logic [`MSG_ADDR_WIDTH-1:0]   addr;
    logic [3:0]                   src_chip;
    logic [3:0]                   src_x;
    logic [3:0]                   src_y;
  } noc_req_hdr_t;

  // Response view of the same word
  // Here dst holds the requester coordinates and src stays zero
  typedef struct packed {
    logic [3:0]                   dst_chip;
    logic [3:0]                   dst_x;
    logic [3:0]                   dst_y;
    logic [`MSG_LENGTH_WIDTH-1:0] msg_length;
    msg_type_e                    msg_type;
    logic [4:0]                   mshrid;
    logic [2:0]                   size_log;
    logic [`MSG_ADDR_WIDTH-1:0]   addr;
    logic [3:0]                   src_chip;
    logic [3:0]                   src_x;
    logic [3:0]                   src_y;
  } noc_resp_hdr_t;

  // Every header flit word is read through one of these two views
  typedef union packed {
    noc_req_hdr_t  req;
    noc_resp_hdr_t resp;
  } noc_hdr_u;

  // Complete request as gathered by the deserializer
  typedef struct packed {
    noc_req_hdr_t               hdr;
    logic [`MEM_LINE_WIDTH-1:0] data;
  } mem_req_t;

  // Memory result with the request header, data flit 0 sits in bits 63 to 0
  typedef struct packed {
    noc_req_hdr_t               hdr;
    logic [`MEM_LINE_WIDTH-1:0] data;
  } mem_resp_t;

endpackage

// File: noc_bridge/noc_bridge_deser.sv
// Packets longer than one line are not supported and one request is held at a time
`timescale 1ns/1ps
`include "noc_bridge_macros.svh"

module noc_bridge_deser
  import noc_bridge_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`NOC_DATA_WIDTH-1:0] flit_in,
  input  logic                       flit_in_val,
  output logic                       flit_in_rdy,
  output mem_req_t                   req,
  output logic                       req_val,
  input  logic                       req_rdy
);

  localparam int words  = `MEM_LINE_WIDTH / `NOC_DATA_WIDTH;
  localparam int word_w = $clog2(words);

  // FSM encoding
  localparam logic [1:0] st_hdr  = 2'd0;
  localparam logic [1:0] st_data = 2'd1;
  localparam logic [1:0] st_hold = 2'd2;

  logic [1:0]                   state;
  noc_hdr_u                     hdr_w;
  noc_req_hdr_t                 hdr_q;
  logic [`MSG_LENGTH_WIDTH-1:0] cnt_q;
  logic [`MSG_LENGTH_WIDTH-1:0] flit_idx;
  logic [`MEM_LINE_WIDTH-1:0]   line_q;
  logic                         flit_in_go;
  logic                         req_go;

  // The incoming word is decoded through the request view of the header union
  assign hdr_w = flit_in;

  // Input is refused while a finished request waits for the memory
  assign flit_in_rdy = (state != st_hold);
  assign req_val     = (state == st_hold);
  assign flit_in_go  = flit_in_val & flit_in_rdy;
  assign req_go      = req_val & req_rdy;

  // Position of the current data flit, counted from the first one after the header
  assign flit_idx = hdr_q.msg_length - cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_hdr;
    end else begin
      case (state)
        st_hdr: begin
          // Loads carry no data and go straight to the memory
          if (flit_in_go) begin
            state <= (hdr_w.req.msg_length == '0) ? st_hold : st_data;
          end
        end
        st_data: begin
          if (flit_in_go && cnt_q == `MSG_LENGTH_WIDTH'd1) begin
            state <= st_hold;
          end
        end
        st_hold: begin
          if (req_go) begin
            state <= st_hdr;
          end
        end
        default: begin
          state <= st_hdr;
        end
      endcase
    end
  end

  // Header, count and line are payload and only move on accepted flits
  always_ff @(posedge clk) begin
    if (flit_in_go && state == st_hdr) begin
      hdr_q <= hdr_w.req;
      cnt_q <= hdr_w.req.msg_length;
    end else if (flit_in_go && state == st_data) begin
      // Each data flit lands in its own word so flit 0 ends up in bits 63 to 0
      line_q[flit_idx[word_w-1:0]*`NOC_DATA_WIDTH +: `NOC_DATA_WIDTH] <= flit_in;
      cnt_q <= cnt_q - `MSG_LENGTH_WIDTH'd1;
    end
  end

  assign req.hdr  = hdr_q;
  assign req.data = line_q;

endmodule

// File: noc_bridge/noc_bridge_ser.sv
// Uncached loads return at most one line and unknown types get a data-less ack
`timescale 1ns/1ps
`include "noc_bridge_macros.svh"

module noc_bridge_ser
  import noc_bridge_pkg::*;
#(
  // Reverse the bytes of every data flit, as a little endian core needs
  parameter bit SWAP_ENDIAN = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  mem_resp_t                  resp,
  input  logic                       resp_val,
  output logic                       resp_rdy,
  output logic [`NOC_DATA_WIDTH-1:0] flit_out,
  output logic                       flit_out_val,
  input  logic                       flit_out_rdy
);

  // FSM encoding
  localparam logic [1:0] st_accept = 2'd0;
  localparam logic [1:0] st_hdr    = 2'd1;
  localparam logic [1:0] st_data   = 2'd2;

  logic [1:0]                   state;
  noc_hdr_u                     hdr_d;
  noc_hdr_u                     hdr_q;
  logic [`MSG_LENGTH_WIDTH-1:0] nc_len;
  logic [`MSG_LENGTH_WIDTH-1:0] cnt_q;
  logic [`MEM_LINE_WIDTH-1:0]   line_q;
  logic [`NOC_DATA_WIDTH-1:0]   data_flit;
  logic                         resp_go;
  logic                         flit_out_go;

  assign resp_rdy     = (state == st_accept);
  assign flit_out_val = (state != st_accept);
  assign resp_go      = resp_val & resp_rdy;
  assign flit_out_go  = flit_out_val & flit_out_rdy;

  // Uncached load length is 2**(size_log-3) flits, at least one
  // Sizes above a line are capped at eight flits
  always_comb begin
    if (resp.hdr.size_log <= 3'd3) begin
      nc_len = `MSG_LENGTH_WIDTH'd1;
    end else if (resp.hdr.size_log >= 3'd6) begin
      nc_len = `MSG_LENGTH_WIDTH'd8;
    end else begin
      nc_len = `MSG_LENGTH_WIDTH'd1 << (resp.hdr.size_log - 3'd3);
    end
  end

  // Acknowledgment header written through the response view
  always_comb begin
    hdr_d               = '0;
    hdr_d.resp.dst_chip = resp.hdr.src_chip;
    hdr_d.resp.dst_x    = resp.hdr.src_x;
    hdr_d.resp.dst_y    = resp.hdr.src_y;
    hdr_d.resp.mshrid   = resp.hdr.mshrid;
    case (resp.hdr.msg_type)
      load_mem: begin
        hdr_d.resp.msg_type   = load_mem_ack;
        hdr_d.resp.msg_length = `MSG_LENGTH_WIDTH'd8;
      end
      store_mem: begin
        hdr_d.resp.msg_type = store_mem_ack;
      end
      nc_load_req: begin
        hdr_d.resp.msg_type   = nc_load_mem_ack;
        hdr_d.resp.msg_length = nc_len;
      end
      nc_store_req: begin
        hdr_d.resp.msg_type = nc_store_mem_ack;
      end
      default: begin
        // Echo the type back with no data so the requester is never left hanging
        hdr_d.resp.msg_type = resp.hdr.msg_type;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_accept;
    end else begin
      case (state)
        st_accept: begin
          if (resp_go) begin
            state <= st_hdr;
          end
        end
        st_hdr: begin
          if (flit_out_go) begin
            state <= (hdr_q.resp.msg_length == '0) ? st_accept : st_data;
          end
        end
        st_data: begin
          if (flit_out_go && cnt_q == `MSG_LENGTH_WIDTH'd1) begin
            state <= st_accept;
          end
        end
        default: begin
          state <= st_accept;
        end
      endcase
    end
  end

  // Header and line are captured on accept, then the line shifts one flit per send
  always_ff @(posedge clk) begin
    if (resp_go) begin
      hdr_q  <= hdr_d;
      line_q <= resp.data;
    end else if (flit_out_go && state == st_hdr) begin
      cnt_q <= hdr_q.resp.msg_length;
    end else if (flit_out_go && state == st_data) begin
      line_q <= line_q >> `NOC_DATA_WIDTH;
      cnt_q  <= cnt_q - `MSG_LENGTH_WIDTH'd1;
    end
  end

  // Optional byte reversal of the flit at the bottom of the line
  always_comb begin
    for (int b = 0; b < `NOC_DATA_WIDTH / 8; b++) begin
      if (SWAP_ENDIAN) begin
        data_flit[8*b +: 8] = line_q[`NOC_DATA_WIDTH-8-8*b +: 8];
      end else begin
        data_flit[8*b +: 8] = line_q[8*b +: 8];
      end
    end
  end

  assign flit_out = (state == st_hdr) ? hdr_q : data_flit;

endmodule

// File: noc_bridge/noc_bridge_top.sv
// One request is in flight per stage, so throughput drops under back-pressure
`timescale 1ns/1ps
`include "noc_bridge_macros.svh"

module noc_bridge_top
  import noc_bridge_pkg::*;
#(
  parameter bit SWAP_ENDIAN = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`NOC_DATA_WIDTH-1:0] flit_in,
  input  logic                       flit_in_val,
  output logic                       flit_in_rdy,
  output logic [`NOC_DATA_WIDTH-1:0] flit_out,
  output logic                       flit_out_val,
  input  logic                       flit_out_rdy
);

  // Request record between deserializer and memory
  mem_req_t  req;
  logic      req_val;
  logic      req_rdy;

  // Response record between memory and serializer
  mem_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  noc_bridge_deser noc_bridge_deser_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flit_in     (flit_in),
    .flit_in_val (flit_in_val),
    .flit_in_rdy (flit_in_rdy),
    .req         (req),
    .req_val     (req_val),
    .req_rdy     (req_rdy)
  );

  bridge_mem bridge_mem_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  noc_bridge_ser #(
    .SWAP_ENDIAN (SWAP_ENDIAN)
  ) noc_bridge_ser_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp         (resp),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .flit_out     (flit_out),
    .flit_out_val (flit_out_val),
    .flit_out_rdy (flit_out_rdy)
  );

endmodule

// File: src/bridge_mem.sv
// Memory contents start undefined and only address bits 9 to 3 select data
`timescale 1ns/1ps
`include "noc_bridge_macros.svh"

module bridge_mem
  import noc_bridge_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mem_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,
  output mem_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  localparam int words  = `MEM_LINE_WIDTH / `NOC_DATA_WIDTH;
  localparam int word_w = $clog2(words);
  localparam int idx_w  = $clog2(`MEM_LINES);

  logic [`MEM_LINE_WIDTH-1:0]   mem_q [`MEM_LINES];
  logic [idx_w-1:0]             line_idx;
  logic [word_w-1:0]            word_idx;
  logic [`MEM_LINE_WIDTH-1:0]   rd_line;
  logic [2*`MEM_LINE_WIDTH-1:0] rd_twice;
  logic                         req_go;
  logic                         resp_go;

  // A new request is taken only once the previous response has left
  assign req_rdy = ~resp_val;
  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // Line index sits above the 64-byte offset and the word index above the byte offset
  assign line_idx = req.hdr.addr[6 +: idx_w];
  assign word_idx = req.hdr.addr[3 +: word_w];
  assign rd_line  = mem_q[line_idx];

  // Doubling the line turns the rotate into a plain right shift
  assign rd_twice = {rd_line, rd_line} >> (word_idx * `NOC_DATA_WIDTH);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_val <= 1'b0;
    end else if (req_go) begin
      resp_val <= 1'b1;
    end else if (resp_go) begin
      resp_val <= 1'b0;
    end
  end

  // Array write and response payload, both updated only on an accepted request
  always_ff @(posedge clk) begin
    if (req_go) begin
      resp.hdr  <= req.hdr;
      resp.data <= '0;
      case (req.hdr.msg_type)
        load_mem: begin
          resp.data <= rd_line;
        end
        nc_load_req: begin
          resp.data <= rd_twice[`MEM_LINE_WIDTH-1:0];
        end
        store_mem: begin
          mem_q[line_idx] <= req.data;
        end
        nc_store_req: begin
          mem_q[line_idx][word_idx*`NOC_DATA_WIDTH +: `NOC_DATA_WIDTH] <=
            req.data[`NOC_DATA_WIDTH-1:0];
        end
        default: begin
          // Other types leave the array alone and return zero data
          resp.data <= '0;
        end
      endcase
    end
  end

endmodule

// File: verif/noc_bridge_tb.sv
// Runs with SWAP_ENDIAN at 0 and fills every line first because the DUT memory starts undefined
`timescale 1ns/1ps
`include "noc_bridge_macros.svh"

module noc_bridge_tb
  import noc_bridge_pkg::*;
();

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic [`NOC_DATA_WIDTH-1:0] flit_in;
  logic                       flit_in_val;
  logic                       flit_in_rdy;
  logic [`NOC_DATA_WIDTH-1:0] flit_out;
  logic                       flit_out_val;
  logic                       flit_out_rdy;

  integer                     seed;
  integer                     bp_seed;
  bit                         bp_en;
  logic [`MEM_LINE_WIDTH-1:0] shadow [`MEM_LINES];
  // Expected output flits in order, with a flag that marks header flits
  logic [`NOC_DATA_WIDTH-1:0] exp_flits [$];
  bit                         exp_is_hdr [$];

  noc_bridge_top #(
    .SWAP_ENDIAN (1'b0)
  ) noc_bridge_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flit_in      (flit_in),
    .flit_in_val  (flit_in_val),
    .flit_in_rdy  (flit_in_rdy),
    .flit_out     (flit_out),
    .flit_out_val (flit_out_val),
    .flit_out_rdy (flit_out_rdy)
  );

  always #20 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("Failure at %0t: %s", $time, what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_hdr(input noc_hdr_u got, input noc_hdr_u exp);
    if (got !== exp) begin
      $display("[ERROR] %0t flit_out header got %h expected %h", $time, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_flit(input logic [`NOC_DATA_WIDTH-1:0] got,
                            input logic [`NOC_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t flit_out data got %h expected %h", $time, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // Builds the acknowledgment and read data from the message rules and keeps the shadow in step
  function automatic noc_hdr_u ref_response(input noc_req_hdr_t h,
                                            input logic [`MEM_LINE_WIDTH-1:0] wdata,
                                            output logic [`MEM_LINE_WIDTH-1:0] rdata);
    noc_hdr_u r;
    int       line;
    int       word;
    int       len;
    int       i;
    r = '0;
    rdata = '0;
    line = h.addr[9:6];
    word = h.addr[5:3];
    r.resp.dst_chip = h.src_chip;
    r.resp.dst_x    = h.src_x;
    r.resp.dst_y    = h.src_y;
    r.resp.mshrid   = h.mshrid;
    case (h.msg_type)
      load_mem: begin
        r.resp.msg_type   = load_mem_ack;
        r.resp.msg_length = 8;
        rdata = shadow[line];
      end
      store_mem: begin
        r.resp.msg_type = store_mem_ack;
        shadow[line] = wdata;
      end
      nc_load_req: begin
        // Two to the power of size_log minus 3 flits, never below one or above a line
        len = (h.size_log <= 3) ? 1 : (1 << (int'(h.size_log) - 3));
        if (len > 8) len = 8;
        r.resp.msg_type   = nc_load_mem_ack;
        r.resp.msg_length = len;
        // The addressed word comes first, then the rest of the line wraps around
        for (i = 0; i < 8; i++) begin
          rdata[64*i +: 64] = shadow[line][64*((word + i) % 8) +: 64];
        end
      end
      default: begin
        r.resp.msg_type = nc_store_mem_ack;
        shadow[line][64*word +: 64] = wdata[63:0];
      end
    endcase
    return r;
  endfunction

  // Each word of a line carries its own byte address in several forms
  function automatic logic [`MEM_LINE_WIDTH-1:0] fill_line(input int line);
    logic [`MEM_LINE_WIDTH-1:0] v;
    logic [15:0]                a;
    int                         w;
    for (w = 0; w < 8; w++) begin
      a = line * 64 + w * 8;
      v[64*w +: 64] = {a ^ 16'hbeef, a, ~a, a ^ 16'h0f0f};
    end
    return v;
  endfunction

  function automatic logic [`MEM_LINE_WIDTH-1:0] rand_line();
    logic [`MEM_LINE_WIDTH-1:0] v;
    int                         i;
    for (i = 0; i < 16; i++) begin
      v[32*i +: 32] = $random(seed);
    end
    return v;
  endfunction

  task automatic send_flit(input logic [`NOC_DATA_WIDTH-1:0] word);
    int waited;
    waited = 0;
    @(negedge clk);
    flit_in     = word;
    flit_in_val = 1'b1;
    // Ready only depends on DUT state, so it is settled at the falling edge
    while (!flit_in_rdy) begin
      @(negedge clk);
      waited++;
      if (waited >= 2000) stop_on_error("timed out waiting for flit_in_rdy");
    end
  endtask

  task automatic issue_request(input msg_type_e t, input logic [15:0] addr,
                               input logic [2:0] size_log,
                               input logic [`MEM_LINE_WIDTH-1:0] data);
    noc_req_hdr_t               h;
    noc_hdr_u                   exp;
    logic [`MEM_LINE_WIDTH-1:0] rdata;
    logic [31:0]                r;
    int                         i;
    h = '0;
    r = $random(seed);
    h.dst_x    = 4'd2;
    h.dst_y    = 4'd3;
    h.src_chip = r[3:0];
    h.src_x    = r[7:4];
    h.src_y    = r[11:8];
    h.mshrid   = r[16:12];
    h.msg_type = t;
    h.size_log = size_log;
    h.addr     = addr;
    h.msg_length = (t == store_mem) ? 8 : ((t == nc_store_req) ? 1 : 0);
    exp = ref_response(h, data, rdata);
    exp_flits.push_back(exp);
    exp_is_hdr.push_back(1'b1);
    for (i = 0; i < exp.resp.msg_length; i++) begin
      exp_flits.push_back(rdata[64*i +: 64]);
      exp_is_hdr.push_back(1'b0);
    end
    send_flit(h);
    for (i = 0; i < h.msg_length; i++) begin
      send_flit(data[64*i +: 64]);
    end
    @(negedge clk);
    flit_in_val = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_flits.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited >= 2000) stop_on_error("timed out waiting for all response flits");
    end
  endtask

  // Picks the ready for the coming edge, then checks the flit that edge will take
  always @(negedge clk) begin : collect
    logic [31:0]                r;
    logic [`NOC_DATA_WIDTH-1:0] exp_word;
    bit                         is_hdr;
    r = $random(bp_seed);
    flit_out_rdy = bp_en ? r[0] : 1'b1;
    if (rst_n && flit_out_val && flit_out_rdy) begin
      if (exp_flits.size() == 0) stop_on_error("flit_out sent a flit no request asked for");
      exp_word = exp_flits.pop_front();
      is_hdr   = exp_is_hdr.pop_front();
      if (is_hdr) check_hdr(flit_out, exp_word);
      else check_flit(flit_out, exp_word);
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    msg_type_e   t;
    int          n;
    seed = 6762;
    // Back-pressure draws from its own random stream, apart from the stimulus
    bp_seed = seed + 1;
    bp_en = 1'b0;
    rst_n = 1'b0;
    flit_in = '0;
    flit_in_val = 1'b0;
    flit_out_rdy = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("flit_out_val", flit_out_val, 1'b0);
    check_bit("flit_in_rdy", flit_in_rdy, 1'b1);
    for (n = 0; n < `MEM_LINES; n++) issue_request(store_mem, n * 64, 3'd0, fill_line(n));
    wait_drain();
    // Line store then line load to the same line
    issue_request(store_mem, 16'h0240, 3'd0, rand_line());
    issue_request(load_mem, 16'h0240, 3'd0, '0);
    // One word written uncached, then read back as 8 bytes
    issue_request(nc_store_req, 16'h0358, 3'd0, rand_line());
    issue_request(nc_load_req, 16'h0358, 3'd3, '0);
    // Every size from 1 byte to a full line
    for (n = 0; n < 7; n++) issue_request(nc_load_req, 16'h0118, n, '0);
    wait_drain();
    bp_en = 1'b1;
    for (n = 0; n < 200; n++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: t = load_mem;
        2'd1: t = store_mem;
        2'd2: t = nc_load_req;
        default: t = nc_store_req;
      endcase
      issue_request(t, r[31:16], r[4:2] % 7, rand_line());
    end
    wait_drain();
    $display("test passed");
    $finish;
  end

endmodule
